/* src/alert_diff_pkg.sv */
package alert_diff_pkg;

  ////////////////////
  // widths
  ////////////////////

  // alert and sigint episode counters share this width
  parameter int cnt_w = 16;

  ////////////////////
  // stage payloads
  ////////////////////

  // one synchronized sample of the differential pair
  // p and n are the resynchronized wire values
  // edge flags mark a change against the previous sample
  typedef struct packed {
    logic p;
    logic n;
    logic p_edge;
    logic n_edge;
  } diff_sample_t;

  // decoded result of one cycle
  // level is the recovered logical value, held through faults
  // rise/fall are single-cycle pulses, evt is their or
  // sigint flags an encoding fault on the pair
  typedef struct packed {
    logic level;
    logic rise;
    logic fall;
    logic evt;
    logic sigint;
  } diff_event_t;

  ////////////////////
  // decoder fsm
  ////////////////////

  // is_std    pair agrees, both wires move together
  // is_skewed one wire moved, the other is expected next cycle
  // sig_int   pair disagrees for too long, wait for recovery
  typedef enum logic [1:0] {
    is_std    = 2'b00,
    is_skewed = 2'b01,
    sig_int   = 2'b10
  } decode_state_e;

endpackage

/* src/diff_sync.sv */
`timescale 1ns/1ps

module diff_sync (
  input  logic                        clk_i,
  input  logic                        rst_b,
  // raw pair from the far clock domain
  input  logic                        diff_p_i,
  input  logic                        diff_n_i,
  // synchronized pair with edge flags
  output alert_diff_pkg::diff_sample_t sample_o
);

  // bit 1 carries n, bit 0 carries p
  // idle encoding of the pair is p=0, n=1
  localparam logic [1:0] PairIdle = 2'b10;

  // first and second synchronizer stages
  logic [1:0] sync1_q;
  logic [1:0] sync2_q;
  // previous synchronized value, for edge detection
  logic [1:0] hist_q;
  logic [1:0] pair_edge;

  ////////////////////
  // synchronizers
  ////////////////////

  // both wires go through the same two-flop chain
  // first flop may go metastable, second one settles it
  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      sync1_q <= PairIdle;
      sync2_q <= PairIdle;
    end else begin
      sync1_q <= {diff_n_i, diff_p_i};
      sync2_q <= sync1_q;
    end
  end

  ////////////////////
  // edge history
  ////////////////////

  // history resets to the idle pair so no edge shows after reset
  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      hist_q <= PairIdle;
    end else begin
      hist_q <= sync2_q;
    end
  end

  // an edge is any difference from the last sample
  // each flag is high for exactly one cycle per wire change
  assign pair_edge = sync2_q ^ hist_q;

  // pack into the stage struct
  assign sample_o.p      = sync2_q[0];
  assign sample_o.n      = sync2_q[1];
  assign sample_o.p_edge = pair_edge[0];
  assign sample_o.n_edge = pair_edge[1];

endmodule

/* src/diff_decode.sv */
`timescale 1ns/1ps

module diff_decode (
  input  logic                        clk_i,
  input  logic                        rst_b,
  // synchronized pair from diff_sync
  input  alert_diff_pkg::diff_sample_t sample_i,
  // registered level, pulses and fault flag
  output alert_diff_pkg::diff_event_t  decoded_o
);

  alert_diff_pkg::decode_state_e state_d;
  alert_diff_pkg::decode_state_e state_q;

  // next value of the output register
  alert_diff_pkg::diff_event_t evt_d;
  // output register, also holds the current level
  alert_diff_pkg::diff_event_t evt_q;

  // pair correctly encoded when the wires disagree
  logic pair_ok;
  // either wire changed this cycle
  logic any_edge;
  // both wires changed this cycle
  logic both_edge;

  assign pair_ok   = sample_i.p ^ sample_i.n;
  assign any_edge  = sample_i.p_edge | sample_i.n_edge;
  assign both_edge = sample_i.p_edge & sample_i.n_edge;

  ////////////////////
  // decode fsm
  ////////////////////

  // legal transitions move both wires in the same sample
  // or one sample apart, a one cycle skew is tolerated
  // anything longer counts as a signal integrity fault
  always_comb begin
    // hold state and level, no pulses by default
    state_d      = state_q;
    evt_d.level  = evt_q.level;
    evt_d.rise   = 1'b0;
    evt_d.fall   = 1'b0;
    evt_d.sigint = 1'b0;

    unique case (state_q)
      // normal operation, pair tracks cleanly
      alert_diff_pkg::is_std: begin
        if (pair_ok) begin
          evt_d.level = sample_i.p;
          // only a joint edge is a clean transition here
          if (both_edge) begin
            evt_d.rise = sample_i.p;
            evt_d.fall = ~sample_i.p;
          end
        end else if (any_edge) begin
          // one wire moved first, give the other one a cycle
          state_d = alert_diff_pkg::is_skewed;
        end else begin
          // disagreement without any movement
          state_d      = alert_diff_pkg::sig_int;
          evt_d.sigint = 1'b1;
        end
      end

      // waiting for the late wire
      alert_diff_pkg::is_skewed: begin
        if (pair_ok) begin
          // late wire caught up, emit the deferred transition
          state_d     = alert_diff_pkg::is_std;
          evt_d.level = sample_i.p;
          evt_d.rise  = sample_i.p;
          evt_d.fall  = ~sample_i.p;
        end else begin
          // skew longer than one cycle
          state_d      = alert_diff_pkg::sig_int;
          evt_d.sigint = 1'b1;
        end
      end

      // fault, level frozen until the pair is valid again
      alert_diff_pkg::sig_int: begin
        if (pair_ok) begin
          // quiet recovery, level follows p from next is_std cycle
          state_d = alert_diff_pkg::is_std;
        end else begin
          evt_d.sigint = 1'b1;
        end
      end

      // unused encoding, fall back to the normal state
      default: begin
        state_d = alert_diff_pkg::is_std;
      end
    endcase

    // combined event pulse
    evt_d.evt = evt_d.rise | evt_d.fall;
  end

  ////////////////////
  // registers
  ////////////////////

  // reset to the idle pair, level low and no pulses
  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      state_q <= alert_diff_pkg::is_std;
      evt_q   <= '0;
    end else begin
      state_q <= state_d;
      evt_q   <= evt_d;
    end
  end

  // stage boundary is the flop output
  assign decoded_o = evt_q;

endmodule

/* src/alert_tracker.sv */
`timescale 1ns/1ps

module alert_tracker #(
  // alert count that raises escalation
  parameter int unsigned EscThresh     = 8,
  // consecutive sigint cycles that raise escalation
  parameter int unsigned SigintHoldMax = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_b,
  // decoded pair from diff_decode
  input  alert_diff_pkg::diff_event_t        decoded_i,
  // single cycle clear of counts and escalation
  input  logic                              clear_i,
  output logic                              level_o,
  output logic                              sigint_o,
  output logic [alert_diff_pkg::cnt_w-1:0]  alert_cnt_o,
  output logic [alert_diff_pkg::cnt_w-1:0]  sigint_cnt_o,
  output logic                              escalate_o
);

  localparam int CntW   = alert_diff_pkg::cnt_w;
  // timer only needs to reach the hold limit
  localparam int TimerW = $clog2(SigintHoldMax + 1);

  localparam logic [CntW-1:0]   EscLimit  = CntW'(EscThresh);
  localparam logic [TimerW-1:0] HoldLimit = TimerW'(SigintHoldMax);

  logic              level_q;
  // delayed sigint, also the previous value for onset detection
  logic              sigint_q;
  logic [CntW-1:0]   alert_cnt_q;
  logic [CntW-1:0]   sigint_cnt_q;
  logic [TimerW-1:0] hold_tmr_q;
  logic              esc_q;

  // sigint rising edge, start of a new episode
  logic              sigint_onset;
  // escalation conditions on the current counts
  logic              cnt_hit;
  logic              hold_hit;

  assign sigint_onset = decoded_i.sigint & ~sigint_q;
  assign cnt_hit      = (alert_cnt_q >= EscLimit);
  assign hold_hit     = (hold_tmr_q >= HoldLimit);

  ////////////////////
  // pass-through regs
  ////////////////////

  // level and sigint are the decoded values one cycle later
  // clear does not touch them, the pair state is not ours to reset
  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      level_q  <= 1'b0;
      sigint_q <= 1'b0;
    end else begin
      level_q  <= decoded_i.level;
      sigint_q <= decoded_i.sigint;
    end
  end

  ////////////////////
  // counters
  ////////////////////

  // clear wins over any count in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      alert_cnt_q  <= '0;
      sigint_cnt_q <= '0;
      hold_tmr_q   <= '0;
      esc_q        <= 1'b0;
    end else if (clear_i) begin
      alert_cnt_q  <= '0;
      sigint_cnt_q <= '0;
      hold_tmr_q   <= '0;
      esc_q        <= 1'b0;
    end else begin
      // every rise on the pair is one alert
      if (decoded_i.rise) begin
        alert_cnt_q <= alert_cnt_q + 1'b1;
      end
      // one count per fault episode
      if (sigint_onset) begin
        sigint_cnt_q <= sigint_cnt_q + 1'b1;
      end
      // duration timer, saturates at the limit, restarts when sigint drops
      if (!decoded_i.sigint) begin
        hold_tmr_q <= '0;
      end else if (!hold_hit) begin
        hold_tmr_q <= hold_tmr_q + 1'b1;
      end
      // sticky until clear
      esc_q <= esc_q | cnt_hit | hold_hit;
    end
  end

  assign level_o      = level_q;
  assign sigint_o     = sigint_q;
  assign alert_cnt_o  = alert_cnt_q;
  assign sigint_cnt_o = sigint_cnt_q;
  assign escalate_o   = esc_q;

endmodule

/* src/alert_rx_top.sv */
`timescale 1ns/1ps

module alert_rx_top #(
  // alert count that raises escalation
  parameter int unsigned EscThresh     = 8,
  // consecutive sigint cycles that raise escalation
  parameter int unsigned SigintHoldMax = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_b,
  // differential alert pair, asynchronous to clk_i
  input  logic                              diff_p_i,
  input  logic                              diff_n_i,
  // clears counts and escalation
  input  logic                              clear_i,
  output logic                              level_o,
  output logic                              sigint_o,
  output logic [alert_diff_pkg::cnt_w-1:0]  alert_cnt_o,
  output logic [alert_diff_pkg::cnt_w-1:0]  sigint_cnt_o,
  output logic                              escalate_o
);

  // synchronizer to decoder
  alert_diff_pkg::diff_sample_t sample;
  // decoder to tracker
  alert_diff_pkg::diff_event_t  decoded;

  ////////////////////
  // stage 1
  ////////////////////

  // resync the pair and flag wire edges
  diff_sync u_sync (
    .clk_i    (clk_i),
    .rst_b    (rst_b),
    .diff_p_i (diff_p_i),
    .diff_n_i (diff_n_i),
    .sample_o (sample)
  );

  ////////////////////
  // stage 2
  ////////////////////

  // skew tolerant decode into level, pulses and faults
  diff_decode u_decode (
    .clk_i     (clk_i),
    .rst_b     (rst_b),
    .sample_i  (sample),
    .decoded_o (decoded)
  );

  ////////////////////
  // stage 3
  ////////////////////

  // alert counting and escalation
  alert_tracker #(
    .EscThresh     (EscThresh),
    .SigintHoldMax (SigintHoldMax)
  ) u_tracker (
    .clk_i        (clk_i),
    .rst_b        (rst_b),
    .decoded_i    (decoded),
    .clear_i      (clear_i),
    .level_o      (level_o),
    .sigint_o     (sigint_o),
    .alert_cnt_o  (alert_cnt_o),
    .sigint_cnt_o (sigint_cnt_o),
    .escalate_o   (escalate_o)
  );

endmodule

/* bench/alert_rx_checker.sv */
`timescale 1ns/1ps

module alert_rx_checker #(
  parameter int unsigned EscThresh     = 8,
  parameter int unsigned SigintHoldMax = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_b,
  // observed UUT outputs
  input  logic                             level_i,
  input  logic                             sigint_i,
  input  logic [alert_diff_pkg::cnt_w-1:0] alert_cnt_i,
  input  logic [alert_diff_pkg::cnt_w-1:0] sigint_cnt_i,
  input  logic                             escalate_i,
  // applied symbol is strobed for one cycle when it starts
  input  logic                             sym_stb_i,
  input  logic [1:0]                       sym_kind_i,
  input  int                               sym_len_i,
  input  logic                             sym_val_i,
  // high while the pins carry an equal pair
  input  logic                             hold_win_i,
  // end of test request
  input  logic                             chk_stb_i,
  input  int                               chk_id_i,
  output int                               test_cnt_o,
  output int                               fail_cnt_o,
  output int                               err_cnt_o
);

  localparam int         CntW       = alert_diff_pkg::cnt_w;
  localparam logic [1:0] KindToggle = 2'd0;
  localparam logic [1:0] KindHold   = 2'd1;
  localparam logic [1:0] KindClear  = 2'd2;

  // expected outputs once a symbol has settled
  typedef struct packed {
    logic            level;
    logic            esc;
    logic [CntW-1:0] alert_cnt;
    logic [CntW-1:0] sigint_cnt;
  } model_t;

  model_t          model;
  // level before the current symbol
  // level_o has to keep it through an equal hold
  logic            pre_level;
  int              test_errs;
  // fault episodes seen as sigint_o onsets since the last clear
  logic [CntW-1:0] sigint_seen;
  // sigint_o one cycle back
  logic            sigint_prev;

  ////////////////////
  // reference model
  ////////////////////

  function automatic model_t next_model(input model_t m, input logic [1:0] kind,
                                        input int len, input logic val);
    model_t r;
    r = m;
    case (kind)
      // clean toggle aligned or skewed by one cycle
      // val is the new p
      KindToggle: begin
        r.level = val;
        if (val && !m.level) begin
          r.alert_cnt = m.alert_cnt + 1'b1;
        end
      end
      // equal pair is one fault episode with quiet recovery to val
      KindHold: begin
        r.sigint_cnt = m.sigint_cnt + 1'b1;
        r.level      = val;
        // first disagreeing sample still reads as a skew
        // the fault starts with the second one
        if (len - 1 >= int'(SigintHoldMax)) begin
          r.esc = 1'b1;
        end
      end
      // counts and escalation drop while level stays
      KindClear: begin
        r.alert_cnt  = '0;
        r.sigint_cnt = '0;
        r.esc        = 1'b0;
      end
      default: begin
      end
    endcase
    if (r.alert_cnt >= CntW'(EscThresh)) begin
      r.esc = 1'b1;
    end
    return r;
  endfunction

  task automatic compare_field(input string name, input logic [CntW-1:0] got,
                               input logic [CntW-1:0] want);
    if (got !== want) begin
      $display("error at time %0t: test %0d %s is %0d, expected %0d",
               $time, chk_id_i, name, got, want);
      test_errs++;
    end
  endtask

  ////////////////////
  // comparison
  ////////////////////

  always @(posedge clk_i) begin
    if (!rst_b) begin
      model       = '0;
      pre_level   = 1'b0;
      test_errs   = 0;
      sigint_seen = '0;
      sigint_prev = 1'b0;
      test_cnt_o  = 0;
      fail_cnt_o  = 0;
      err_cnt_o   = 0;
    end else begin
      // each rising edge of sigint_o is one observed fault episode
      if (sigint_i && !sigint_prev) begin
        sigint_seen = sigint_seen + 1'b1;
      end
      sigint_prev = sigint_i;
      if (sym_stb_i) begin
        pre_level = model.level;
        model     = next_model(model, sym_kind_i, sym_len_i, sym_val_i);
        if (sym_kind_i == KindClear) begin
          sigint_seen = '0;
        end
      end
      // level must not move while the pair is in a fault
      if (hold_win_i && level_i !== pre_level) begin
        $display("error at time %0t: level_o moved to %0d during an equal hold",
                 $time, level_i);
        test_errs++;
      end
      // outputs are settled here so every field is compared
      if (chk_stb_i) begin
        compare_field("level_o", CntW'(level_i), CntW'(model.level));
        compare_field("sigint_o", CntW'(sigint_i), '0);
        compare_field("sigint_o episodes", sigint_seen, model.sigint_cnt);
        compare_field("alert_cnt_o", alert_cnt_i, model.alert_cnt);
        compare_field("sigint_cnt_o", sigint_cnt_i, model.sigint_cnt);
        compare_field("escalate_o", CntW'(escalate_i), CntW'(model.esc));
        test_cnt_o++;
        err_cnt_o += test_errs;
        if (test_errs == 0) begin
          $display("test %0d passed", chk_id_i);
        end else begin
          $display("test %0d failed with %0d mismatches", chk_id_i, test_errs);
          fail_cnt_o++;
        end
        test_errs = 0;
      end
    end
  end

endmodule

/* bench/alert_rx_tb.sv */
`timescale 1ns/1ps

module alert_rx_tb;

  localparam int unsigned EscThresh     = 8;
  localparam int unsigned SigintHoldMax = 32;
  localparam int          ResetCycles   = 10;
  // settle after each symbol, covers the 5 cycle skewed latency
  localparam int          Settle        = 10;
  localparam int          NumTests      = 8;
  // symbols incl idle steps, and the summed equal hold lengths
  localparam int          NumSymbols    = 46;
  localparam int          HoldCycles    = 83;
  localparam int          TimeoutCycles = ResetCycles + NumSymbols * (Settle + 2) +
                                          HoldCycles + NumTests * 2 + 64;
  localparam logic [1:0]  KindToggle    = 2'd0;
  localparam logic [1:0]  KindHold      = 2'd1;
  localparam logic [1:0]  KindClear     = 2'd2;

  logic                             clk_i;
  logic                             rst_b;
  logic                             diff_p_i;
  logic                             diff_n_i;
  logic                             clear_i;
  logic                             level_o;
  logic                             sigint_o;
  logic [alert_diff_pkg::cnt_w-1:0] alert_cnt_o;
  logic [alert_diff_pkg::cnt_w-1:0] sigint_cnt_o;
  logic                             escalate_o;

  // symbol and check strobes to the checker
  logic        sym_stb;
  logic [1:0]  sym_kind;
  int          sym_len;
  logic        sym_val;
  logic        hold_win;
  logic        chk_stb;
  int          chk_id;
  int          test_cnt;
  int          fail_cnt;
  int          err_cnt;
  logic [31:0] rng;
  // p level currently on the pins
  logic        cur_p;
  int          cycle_cnt = 0;

  always #20 clk_i = ~clk_i;

  alert_rx_top #(
    .EscThresh     (EscThresh),
    .SigintHoldMax (SigintHoldMax)
  ) UUT (
    .clk_i        (clk_i),
    .rst_b        (rst_b),
    .diff_p_i     (diff_p_i),
    .diff_n_i     (diff_n_i),
    .clear_i      (clear_i),
    .level_o      (level_o),
    .sigint_o     (sigint_o),
    .alert_cnt_o  (alert_cnt_o),
    .sigint_cnt_o (sigint_cnt_o),
    .escalate_o   (escalate_o)
  );

  alert_rx_checker #(
    .EscThresh     (EscThresh),
    .SigintHoldMax (SigintHoldMax)
  ) u_checker (
    .clk_i        (clk_i),
    .rst_b        (rst_b),
    .level_i      (level_o),
    .sigint_i     (sigint_o),
    .alert_cnt_i  (alert_cnt_o),
    .sigint_cnt_i (sigint_cnt_o),
    .escalate_i   (escalate_o),
    .sym_stb_i    (sym_stb),
    .sym_kind_i   (sym_kind),
    .sym_len_i    (sym_len),
    .sym_val_i    (sym_val),
    .hold_win_i   (hold_win),
    .chk_stb_i    (chk_stb),
    .chk_id_i     (chk_id),
    .test_cnt_o   (test_cnt),
    .fail_cnt_o   (fail_cnt),
    .err_cnt_o    (err_cnt)
  );

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic post_symbol(input logic [1:0] kind, input int len, input logic val);
    sym_kind = kind;
    sym_len  = len;
    sym_val  = val;
    sym_stb  = 1'b1;
  endtask

  // mode 0 aligned, 1 p moves first, 2 n moves first
  task automatic toggle_pair(input int mode);
    logic np;
    np = ~cur_p;
    @(negedge clk_i);
    post_symbol(KindToggle, 0, np);
    if (mode != 2) diff_p_i = np;
    if (mode != 1) diff_n_i = ~np;
    @(negedge clk_i);
    sym_stb  = 1'b0;
    // late wire catches up one cycle later
    diff_p_i = np;
    diff_n_i = ~np;
    cur_p    = np;
    repeat (Settle) @(negedge clk_i);
  endtask

  // both wires at val for len cycles, then back to a valid pair at rec
  task automatic hold_pair(input logic val, input int len, input logic rec);
    @(negedge clk_i);
    post_symbol(KindHold, len, rec);
    diff_p_i = val;
    diff_n_i = val;
    hold_win = 1'b1;
    @(negedge clk_i);
    sym_stb = 1'b0;
    repeat (len - 1) @(negedge clk_i);
    hold_win = 1'b0;
    diff_p_i = rec;
    diff_n_i = ~rec;
    cur_p    = rec;
    repeat (Settle) @(negedge clk_i);
  endtask

  task automatic pulse_clear();
    @(negedge clk_i);
    post_symbol(KindClear, 0, 1'b0);
    clear_i = 1'b1;
    @(negedge clk_i);
    sym_stb = 1'b0;
    clear_i = 1'b0;
    repeat (Settle) @(negedge clk_i);
  endtask

  task automatic finish_test(input int id);
    @(negedge clk_i);
    chk_id  = id;
    chk_stb = 1'b1;
    @(negedge clk_i);
    chk_stb = 1'b0;
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    clk_i    = 1'b0;
    rst_b    = 1'b0;
    diff_p_i = 1'b0;
    diff_n_i = 1'b1;
    clear_i  = 1'b0;
    sym_stb  = 1'b0;
    sym_kind = KindToggle;
    sym_len  = 0;
    sym_val  = 1'b0;
    hold_win = 1'b0;
    chk_stb  = 1'b0;
    chk_id   = 0;
    rng      = 32'h7770;
    cur_p    = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_b = 1'b1;
    repeat (Settle) @(negedge clk_i);
    // reset values, no stimulus yet
    finish_test(1);
    // random aligned toggles, a skipped step just idles
    pulse_clear();
    for (int i = 0; i < 12; i++) begin
      rng = xorshift32(rng);
      if (rng[0]) toggle_pair(0);
      else repeat (Settle) @(negedge clk_i);
    end
    finish_test(2);
    // one cycle skew on either wire
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      toggle_pair(rng[1] ? 1 : 2);
    end
    finish_test(3);
    // equal holds, recovering to both levels
    hold_pair(1'b0, 4, 1'b1);
    hold_pair(1'b1, 6, 1'b0);
    hold_pair(1'b0, 3, 1'b0);
    hold_pair(1'b1, 5, 1'b1);
    finish_test(4);
    // 16 toggles give 8 rises, enough to escalate
    pulse_clear();
    for (int i = 0; i < 16; i++) toggle_pair(0);
    finish_test(5);
    pulse_clear();
    finish_test(6);
    // short fault stays under the duration limit
    pulse_clear();
    hold_pair(1'b0, 5, cur_p);
    finish_test(7);
    hold_pair(1'b1, 60, ~cur_p);
    finish_test(8);
    repeat (2) @(negedge clk_i);
    $display("closing: %0d tests run, %0d failed, %0d mismatches", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && test_cnt == NumTests) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // run limit from the summed symbol lengths
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("run timed out after %0d cycles before the tests finished", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

/* alert_rx_top.f */
src/alert_diff_pkg.sv
src/diff_sync.sv
src/diff_decode.sv
src/alert_tracker.sv
src/alert_rx_top.sv
bench/alert_rx_checker.sv
bench/alert_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module alert_rx_tb \
  --Mdir obj_dir -o alert_rx_sim -f alert_rx_top.f

out=$(./obj_dir/alert_rx_sim)
echo "$out"

if echo "$out" | grep -q "Finished with no errors"; then
  exit 0
else
  exit 1
fi
